// ==== Bender.yml ====
package:
  name: radio_ctrl

sources:
  - radio_pkg.sv
  - setting_decoder.sv
  - atr_gpio_ctrl.sv
  - fe_iq_corrector.sv
  - readback_mux.sv
  - radio_ctrl_top.sv
  - target: test
    files:
      - tb_radio_ctrl.sv

// ==== atr_gpio_ctrl.sv ====
// atr state select for one slot; rx flags are ORed so channels cannot drive gpio separately
`timescale 1ns/1ns

module atr_gpio_ctrl (
   input  logic                                  radio_clk,
   input  logic                                  i_rst_n,
   input  radio_pkg::db_cfg_t                    i_db_cfg,
   input  logic [radio_pkg::NUM_RX_CHANNELS-1:0] i_rx_running,
   input  logic                                  i_tx_running,
   output radio_pkg::atr_state_t                 o_atr_state,
   output logic [radio_pkg::DATA_W-1:0]          o_gpio_out,
   output logic [radio_pkg::DATA_W-1:0]          o_gpio_ddr,
   output logic [2:0]                            o_leds
);

   import radio_pkg::*;

   logic              rx_any;     // any rx channel running
   logic [DATA_W-1:0] atr_word;   // word for current state

   assign rx_any = |i_rx_running;

   // state straight from run flags, {tx, rx}
   assign o_atr_state = atr_state_t'({i_tx_running, rx_any});

   // --------------------
   // atr word select
   // --------------------
   always_comb
   begin
      case (o_atr_state)
         ATR_IDLE : atr_word = i_db_cfg.atr_idle;
         ATR_RX   : atr_word = i_db_cfg.atr_rx;
         ATR_TX   : atr_word = i_db_cfg.atr_tx;
         default  : atr_word = i_db_cfg.atr_full;  // full duplex
      endcase
   end

   // --------------------
   // registered outputs
   // --------------------
   always_ff @(posedge radio_clk)
   begin
      if (!i_rst_n)
      begin
         o_gpio_out <= '0;
         o_gpio_ddr <= '0;
         o_leds     <= '0;
      end
      else
      begin
         o_gpio_out <= atr_word;
         o_gpio_ddr <= i_db_cfg.gpio_ddr;
         // led order is {rx, txrx_tx, txrx_rx}
         o_leds[2] <= rx_any & ~i_tx_running;  // rx only
         o_leds[1] <= i_tx_running;
         o_leds[0] <= rx_any & i_tx_running;   // full duplex
      end
   end

endmodule

// ==== fe_iq_corrector.sv ====
// two-stage i/q front-end fix for one channel; config is not sampled with the data, change it when idle
`timescale 1ns/1ns

module fe_iq_corrector (
   input  logic                  radio_clk,
   input  logic                  i_rst_n,
   input  radio_pkg::fe_cfg_t    i_cfg,
   input  logic                  i_stb,
   input  radio_pkg::iq_sample_t i_sample,
   output logic                  o_stb,
   output radio_pkg::iq_sample_t o_sample
);

   import radio_pkg::*;

   localparam logic signed [SAMPLE_W-1:0] S_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
   localparam logic signed [SAMPLE_W-1:0] S_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

   logic signed [SAMPLE_W-1:0] sw_i, sw_q;   // after swap
   logic                       st1_stb;
   iq_sample_t                 st1_sample;

   // negate, most negative clips to most positive
   function automatic logic signed [SAMPLE_W-1:0] neg_sat(input logic signed [SAMPLE_W-1:0] x);
      if (x == S_MIN)
         return S_MAX;
      return -x;
   endfunction

   // add with clip to signed range
   function automatic logic signed [SAMPLE_W-1:0] add_sat(
      input logic signed [SAMPLE_W-1:0] a,
      input logic signed [SAMPLE_W-1:0] b
   );
      logic signed [SAMPLE_W:0] sum;
      sum = a + b;  // one guard bit
      if (sum[SAMPLE_W] != sum[SAMPLE_W-1])
         return sum[SAMPLE_W] ? S_MIN : S_MAX;
      return sum[SAMPLE_W-1:0];
   endfunction

   assign sw_i = i_cfg.swap ? i_sample.q : i_sample.i;
   assign sw_q = i_cfg.swap ? i_sample.i : i_sample.q;

   // --------------------
   // stage 1: swap, negate
   // stage 2: dc offset
   // --------------------
   always_ff @(posedge radio_clk)
   begin
      if (!i_rst_n)
      begin
         st1_stb    <= 1'b0;
         st1_sample <= '0;
         o_stb      <= 1'b0;
         o_sample   <= '0;
      end
      else
      begin
         st1_stb      <= i_stb;
         st1_sample.i <= i_cfg.neg_i ? neg_sat(sw_i) : sw_i;
         st1_sample.q <= i_cfg.neg_q ? neg_sat(sw_q) : sw_q;
         o_stb        <= st1_stb;                          // strobe follows data
         o_sample.i   <= add_sat(st1_sample.i, i_cfg.dc_i);
         o_sample.q   <= add_sat(st1_sample.q, i_cfg.dc_q);
      end
   end

endmodule

// ==== radio_ctrl_tests.txt ====
# ops in hex: W addr data | R addr expected | X chan i q exp_i exp_q (chan 2 is tx)
# A rx_run tx_run exp_gpio exp_leds | I gpio_in misc_in
A 0 0 00000000 0
R 10 0000000000000000
R 11 0000000000000000
R 12 0000000000000000
W a0 11110000
W a1 22220001
W a2 33330002
W a3 44440003
A 0 0 11110000 0
A 2 0 22220001 4
A 0 1 33330002 2
A 3 1 44440003 3
X 0 1234 abcd 1234 abcd
X 0 7fff 8000 7fff 8000
X 1 0001 ffff 0001 ffff
X 1 5a5a a5a5 5a5a a5a5
W f0 00000007
W f1 01000000
X 1 8000 0010 00f0 7fff
X 1 0005 7f80 8180 fffb
W d1 70009000
X 2 2000 e000 7fff 8000
X 2 0100 0100 7100 9100
W a4 0000ff00
W a5 cafe0001
I 5a5a0000 00c0ffee
R 11 00c0ffeecafe0001
R 10 5a5a000044440003
R 12 0000ff0000000003
R 13 0000000000000000

// ==== radio_ctrl_top.f ====
radio_pkg.sv
setting_decoder.sv
atr_gpio_ctrl.sv
fe_iq_corrector.sv
readback_mux.sv
radio_ctrl_top.sv
tb_radio_ctrl.sv

// ==== radio_ctrl_top.sv ====
// radio-clock control slice; one db slot, settings and samples synchronous to radio_clk, no back-pressure
`timescale 1ns/1ns

module radio_ctrl_top (
   input  logic                                                    i_rst_n,
   input  logic                                                    radio_clk,
   // settings bus
   input  logic                                                    i_set_stb,
   input  logic [radio_pkg::ADDR_W-1:0]                            i_set_addr,
   input  logic [radio_pkg::DATA_W-1:0]                            i_set_data,
   // readback
   input  logic                                                    i_rb_stb,
   input  logic [radio_pkg::ADDR_W-1:0]                            i_rb_addr,
   output logic                                                    o_rb_valid,
   output logic [radio_pkg::RB_W-1:0]                              o_rb_data,
   // run flags
   input  logic [radio_pkg::NUM_RX_CHANNELS-1:0]                   i_rx_running,
   input  logic                                                    i_tx_running,
   // sample streams
   input  logic [radio_pkg::NUM_RX_CHANNELS-1:0]                   i_rx_stb,
   input  radio_pkg::iq_sample_t [radio_pkg::NUM_RX_CHANNELS-1:0]  i_rx_samples,
   output logic [radio_pkg::NUM_RX_CHANNELS-1:0]                   o_rx_stb,
   output radio_pkg::iq_sample_t [radio_pkg::NUM_RX_CHANNELS-1:0]  o_rx_samples,
   input  logic                                                    i_tx_stb,
   input  radio_pkg::iq_sample_t                                   i_tx_sample,
   output logic                                                    o_tx_stb,
   output radio_pkg::iq_sample_t                                   o_tx_sample,
   // db pins
   input  logic [radio_pkg::DATA_W-1:0]                            i_db_gpio_in,
   output logic [radio_pkg::DATA_W-1:0]                            o_db_gpio_out,
   output logic [radio_pkg::DATA_W-1:0]                            o_db_gpio_ddr,
   output logic [2:0]                                              o_radio_led,
   input  logic [radio_pkg::DATA_W-1:0]                            i_misc_in,
   output logic [radio_pkg::DATA_W-1:0]                            o_misc_out
);

   import radio_pkg::*;

   db_cfg_t                         db_cfg;
   fe_cfg_t [NUM_RX_CHANNELS-1:0]   rx_fe_cfg;
   fe_cfg_t                         tx_fe_cfg;
   atr_state_t                      atr_state;

   // --------------------
   // settings
   // --------------------
   setting_decoder u_setting_decoder (
      .radio_clk   (radio_clk),
      .i_rst_n     (i_rst_n),
      .i_set_stb   (i_set_stb),
      .i_set_addr  (i_set_addr),
      .i_set_data  (i_set_data),
      .o_db_cfg    (db_cfg),
      .o_rx_fe_cfg (rx_fe_cfg),
      .o_tx_fe_cfg (tx_fe_cfg)
   );

   assign o_misc_out = db_cfg.misc_out;  // no extra flop

   atr_gpio_ctrl u_atr_gpio_ctrl (
      .radio_clk    (radio_clk),
      .i_rst_n      (i_rst_n),
      .i_db_cfg     (db_cfg),
      .i_rx_running (i_rx_running),
      .i_tx_running (i_tx_running),
      .o_atr_state  (atr_state),
      .o_gpio_out   (o_db_gpio_out),
      .o_gpio_ddr   (o_db_gpio_ddr),
      .o_leds       (o_radio_led)
   );

   // --------------------
   // front ends
   // --------------------
   for (genvar ch = 0; ch < NUM_RX_CHANNELS; ch++)
   begin : g_rx_fe
      fe_iq_corrector u_rx_fe (
         .radio_clk (radio_clk),
         .i_rst_n   (i_rst_n),
         .i_cfg     (rx_fe_cfg[ch]),
         .i_stb     (i_rx_stb[ch]),
         .i_sample  (i_rx_samples[ch]),
         .o_stb     (o_rx_stb[ch]),
         .o_sample  (o_rx_samples[ch])
      );
   end

   fe_iq_corrector u_tx_fe (
      .radio_clk (radio_clk),
      .i_rst_n   (i_rst_n),
      .i_cfg     (tx_fe_cfg),
      .i_stb     (i_tx_stb),
      .i_sample  (i_tx_sample),
      .o_stb     (o_tx_stb),
      .o_sample  (o_tx_sample)
   );

   readback_mux u_readback_mux (
      .radio_clk   (radio_clk),
      .i_rst_n     (i_rst_n),
      .i_rb_stb    (i_rb_stb),
      .i_rb_addr   (i_rb_addr),
      .i_db_cfg    (db_cfg),
      .i_atr_state (atr_state),
      .i_gpio_in   (i_db_gpio_in),
      .i_gpio_out  (o_db_gpio_out),
      .i_misc_in   (i_misc_in),
      .o_rb_valid  (o_rb_valid),
      .o_rb_data   (o_rb_data)
   );

endmodule

// ==== radio_pkg.sv ====
// shared widths, register map and types; one db slot, two rx channels, one tx channel, no back-pressure
package radio_pkg;

   // --------------------
   // widths
   // --------------------
   localparam int DATA_W          = 32;   // settings word, gpio word
   localparam int ADDR_W          = 8;    // settings and readback address
   localparam int RB_W            = 64;   // readback word
   localparam int SAMPLE_W        = 16;   // one i or q component
   localparam int NUM_RX_CHANNELS = 2;

   // --------------------
   // settings register map
   // --------------------
   localparam logic [ADDR_W-1:0] SR_DB_BASE    = 8'd160;
   localparam logic [ADDR_W-1:0] DB_ATR_IDLE   = 8'd0;
   localparam logic [ADDR_W-1:0] DB_ATR_RX     = 8'd1;
   localparam logic [ADDR_W-1:0] DB_ATR_TX     = 8'd2;
   localparam logic [ADDR_W-1:0] DB_ATR_FULL   = 8'd3;
   localparam logic [ADDR_W-1:0] DB_GPIO_DDR   = 8'd4;
   localparam logic [ADDR_W-1:0] DB_MISC_OUT   = 8'd5;

   localparam logic [ADDR_W-1:0] SR_TX_FE_BASE     = 8'd208;
   localparam logic [ADDR_W-1:0] SR_RX_FE_BASE     = 8'd224;
   localparam logic [ADDR_W-1:0] SR_FE_CHAN_OFFSET = 8'd16;  // step between rx channels
   localparam logic [ADDR_W-1:0] FE_MODE           = 8'd0;   // bit0 swap, bit1 neg i, bit2 neg q
   localparam logic [ADDR_W-1:0] FE_DC_OFFSET      = 8'd1;   // i in [31:16], q in [15:0]

   // readback map
   localparam logic [ADDR_W-1:0] RB_DB_BASE = 8'd16;
   localparam logic [ADDR_W-1:0] RB_GPIO    = 8'd0;  // {gpio in, gpio out}
   localparam logic [ADDR_W-1:0] RB_MISC    = 8'd1;  // {misc in, misc out}
   localparam logic [ADDR_W-1:0] RB_ATR     = 8'd2;  // {gpio ddr, zeros, atr state}

   // --------------------
   // types
   // --------------------
   typedef struct packed {
      logic signed [SAMPLE_W-1:0] i;  // upper half
      logic signed [SAMPLE_W-1:0] q;
   } iq_sample_t;

   typedef struct packed {
      logic                       neg_q;
      logic                       neg_i;
      logic                       swap;
      logic signed [SAMPLE_W-1:0] dc_i;
      logic signed [SAMPLE_W-1:0] dc_q;
   } fe_cfg_t;

   typedef struct packed {
      logic [DATA_W-1:0] atr_idle;
      logic [DATA_W-1:0] atr_rx;
      logic [DATA_W-1:0] atr_tx;
      logic [DATA_W-1:0] atr_full;
      logic [DATA_W-1:0] gpio_ddr;
      logic [DATA_W-1:0] misc_out;
   } db_cfg_t;

   // encoded as {tx, rx}
   typedef enum logic [1:0] {
      ATR_IDLE = 2'b00,
      ATR_RX   = 2'b01,
      ATR_TX   = 2'b10,
      ATR_FULL = 2'b11
   } atr_state_t;

endpackage

// ==== readback_mux.sv ====
// readback for the db slot; one answer per request a cycle later, misc in needs two stable cycles
`timescale 1ns/1ns

module readback_mux (
   input  logic                         radio_clk,
   input  logic                         i_rst_n,
   input  logic                         i_rb_stb,
   input  logic [radio_pkg::ADDR_W-1:0] i_rb_addr,
   input  radio_pkg::db_cfg_t           i_db_cfg,
   input  radio_pkg::atr_state_t        i_atr_state,
   input  logic [radio_pkg::DATA_W-1:0] i_gpio_in,
   input  logic [radio_pkg::DATA_W-1:0] i_gpio_out,
   input  logic [radio_pkg::DATA_W-1:0] i_misc_in,
   output logic                         o_rb_valid,
   output logic [radio_pkg::RB_W-1:0]   o_rb_data
);

   import radio_pkg::*;

   logic [DATA_W-1:0] misc_in_r;  // misc pins, one flop
   logic [RB_W-1:0]   rb_word;

   // --------------------
   // word select
   // --------------------
   always_comb
   begin
      case (i_rb_addr)
         RB_DB_BASE + RB_GPIO : rb_word = {i_gpio_in, i_gpio_out};
         RB_DB_BASE + RB_MISC : rb_word = {misc_in_r, i_db_cfg.misc_out};
         // ddr moved to the upper word, state in bits 1:0
         RB_DB_BASE + RB_ATR  : rb_word = {i_db_cfg.gpio_ddr, {(DATA_W-2){1'b0}}, i_atr_state};
         default              : rb_word = '0;  // unmapped reads zero
      endcase
   end

   always_ff @(posedge radio_clk)
   begin
      if (!i_rst_n)
      begin
         misc_in_r  <= '0;
         o_rb_valid <= 1'b0;
         o_rb_data  <= '0;
      end
      else
      begin
         misc_in_r  <= i_misc_in;
         o_rb_valid <= i_rb_stb;  // every request answered
         if (i_rb_stb)
            o_rb_data <= rb_word;  // hold last answer otherwise
      end
   end

endmodule

// ==== setting_decoder.sv ====
// settings bus write decoder; single-cycle strobe, unmapped addresses ignored, one cycle to config
`timescale 1ns/1ns

module setting_decoder (
   input  logic                                                 radio_clk,
   input  logic                                                 i_rst_n,
   input  logic                                                 i_set_stb,
   input  logic [radio_pkg::ADDR_W-1:0]                         i_set_addr,
   input  logic [radio_pkg::DATA_W-1:0]                         i_set_data,
   output radio_pkg::db_cfg_t                                   o_db_cfg,
   output radio_pkg::fe_cfg_t [radio_pkg::NUM_RX_CHANNELS-1:0]  o_rx_fe_cfg,
   output radio_pkg::fe_cfg_t                                   o_tx_fe_cfg
);

   import radio_pkg::*;

   // merge one settings word into a front-end config
   function automatic fe_cfg_t fe_write(
      input fe_cfg_t           cur,
      input logic              is_dc,   // 1: dc offset word, 0: mode word
      input logic [DATA_W-1:0] data
   );
      fe_cfg_t nxt;
      nxt = cur;
      if (is_dc)
      begin
         nxt.dc_i = data[DATA_W-1:SAMPLE_W];  // i upper
         nxt.dc_q = data[SAMPLE_W-1:0];
      end
      else
      begin
         nxt.swap  = data[0];
         nxt.neg_i = data[1];
         nxt.neg_q = data[2];
      end
      return nxt;
   endfunction

   // --------------------
   // db register bank
   // --------------------
   always_ff @(posedge radio_clk)
   begin
      if (!i_rst_n)
      begin
         o_db_cfg <= '0;
      end
      else if (i_set_stb)
      begin
         case (i_set_addr)
            SR_DB_BASE + DB_ATR_IDLE : o_db_cfg.atr_idle <= i_set_data;
            SR_DB_BASE + DB_ATR_RX   : o_db_cfg.atr_rx   <= i_set_data;
            SR_DB_BASE + DB_ATR_TX   : o_db_cfg.atr_tx   <= i_set_data;
            SR_DB_BASE + DB_ATR_FULL : o_db_cfg.atr_full <= i_set_data;
            SR_DB_BASE + DB_GPIO_DDR : o_db_cfg.gpio_ddr <= i_set_data;
            SR_DB_BASE + DB_MISC_OUT : o_db_cfg.misc_out <= i_set_data;
            default                  : ;  // not ours
         endcase
      end
   end

   // --------------------
   // front-end banks
   // --------------------
   always_ff @(posedge radio_clk)
   begin
      if (!i_rst_n)
      begin
         o_tx_fe_cfg <= '0;
      end
      else if (i_set_stb)
      begin
         if (i_set_addr == SR_TX_FE_BASE + FE_MODE)
            o_tx_fe_cfg <= fe_write(o_tx_fe_cfg, 1'b0, i_set_data);
         else if (i_set_addr == SR_TX_FE_BASE + FE_DC_OFFSET)
            o_tx_fe_cfg <= fe_write(o_tx_fe_cfg, 1'b1, i_set_data);
      end
   end

   // rx channels sit SR_FE_CHAN_OFFSET apart
   always_ff @(posedge radio_clk)
   begin
      if (!i_rst_n)
      begin
         o_rx_fe_cfg <= '0;
      end
      else if (i_set_stb)
      begin
         for (int ch = 0; ch < NUM_RX_CHANNELS; ch++)
         begin
            if (i_set_addr == ADDR_W'(SR_RX_FE_BASE + ch * SR_FE_CHAN_OFFSET + FE_MODE))
               o_rx_fe_cfg[ch] <= fe_write(o_rx_fe_cfg[ch], 1'b0, i_set_data);
            else if (i_set_addr == ADDR_W'(SR_RX_FE_BASE + ch * SR_FE_CHAN_OFFSET + FE_DC_OFFSET))
               o_rx_fe_cfg[ch] <= fe_write(o_rx_fe_cfg[ch], 1'b1, i_set_data);
         end
      end
   end

endmodule

// ==== tb_radio_ctrl.sv ====
// reads radio_ctrl_tests.txt from the project root; one sample strobe per cycle, config writes only when idle
`timescale 1ns/1ns

module tb_radio_ctrl;

   import radio_pkg::*;

   localparam int CLK_PERIOD = 10;
   localparam int RB_WAIT    = 8;    // cycles allowed for a readback answer
   localparam int DRAIN_WAIT = 10;   // cycles allowed for samples to leave

   // one sample in flight through a corrector
   typedef struct packed {
      logic [1:0]  chan;   // 2 is tx
      logic [63:0] t_drv;  // time its strobe was driven
      logic [15:0] exp_i;
      logic [15:0] exp_q;
   } flight_t;

   logic                              radio_clk;
   logic                              i_rst_n;
   logic                              i_set_stb;
   logic [ADDR_W-1:0]                 i_set_addr;
   logic [DATA_W-1:0]                 i_set_data;
   logic                              i_rb_stb;
   logic [ADDR_W-1:0]                 i_rb_addr;
   logic                              o_rb_valid;
   logic [RB_W-1:0]                   o_rb_data;
   logic [NUM_RX_CHANNELS-1:0]        i_rx_running;
   logic                              i_tx_running;
   logic [NUM_RX_CHANNELS-1:0]        i_rx_stb;
   iq_sample_t [NUM_RX_CHANNELS-1:0]  i_rx_samples;
   logic [NUM_RX_CHANNELS-1:0]        o_rx_stb;
   iq_sample_t [NUM_RX_CHANNELS-1:0]  o_rx_samples;
   logic                              i_tx_stb;
   iq_sample_t                        i_tx_sample;
   logic                              o_tx_stb;
   iq_sample_t                        o_tx_sample;
   logic [DATA_W-1:0]                 i_db_gpio_in;
   logic [DATA_W-1:0]                 o_db_gpio_out;
   logic [DATA_W-1:0]                 o_db_gpio_ddr;
   logic [2:0]                        o_radio_led;
   logic [DATA_W-1:0]                 i_misc_in;
   logic [DATA_W-1:0]                 o_misc_out;

   flight_t flight_q[$];      // samples sent, oldest first
   int      pass_cnt  = 0;
   int      fail_cnt  = 0;
   int      wd_cycles = 0;    // set once the file is counted

   radio_ctrl_top dut0 (.*);

   initial
   begin
      radio_clk = 1'b0;
      forever #(CLK_PERIOD / 2) radio_clk = ~radio_clk;
   end

   // --------------------
   // watchdog
   // --------------------
   initial
   begin
      wait (wd_cycles > 0);
      #(wd_cycles * CLK_PERIOD);
      $display("timeout: tests still running after %0d cycles", wd_cycles);
      $display("Simulation failed");
      $finish;
   end

   function automatic bit match_value(input string sig, input logic [63:0] exp_v,
                                      input logic [63:0] got_v);
      if (exp_v !== got_v)
      begin
         $display("[FAIL] t=%0t %s expected %h got %h", $time, sig, exp_v, got_v);
         return 1'b0;
      end
      return 1'b1;
   endfunction

   function automatic string sample_name(input int chan, input string comp);
      if (chan == NUM_RX_CHANNELS)
         return {"o_tx_sample.", comp};
      return $sformatf("o_rx_samples[%0d].%s", chan, comp);
   endfunction

   task automatic finish_test(input string name, input bit ok);
      if (ok)
         pass_cnt++;
      else
         fail_cnt++;
      $display("test %0d %s: %s", pass_cnt + fail_cnt, name, ok ? "pass" : "failed");
   endtask

   task automatic skip_line(input int fd);
      int c;
      c = $fgetc(fd);
      while (c != -1 && c != "\n")
         c = $fgetc(fd);
   endtask

   task automatic bad_line(input int fd, input logic [7:0] op);
      $display("line starting with '%c' could not be read", op);
      fail_cnt++;
      skip_line(fd);
   endtask

   // --------------------
   // bus and pin drivers
   // --------------------
   task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      @(posedge radio_clk);
      i_set_stb  <= 1'b1;
      i_set_addr <= addr;
      i_set_data <= data;
      @(posedge radio_clk);
      i_set_stb  <= 1'b0;   // single-cycle strobe
   endtask

   task automatic set_pins(input logic [DATA_W-1:0] gpio_in, input logic [DATA_W-1:0] misc_in);
      @(posedge radio_clk);
      i_db_gpio_in <= gpio_in;
      i_misc_in    <= misc_in;
      repeat (2) @(posedge radio_clk);   // misc in passes one flop
   endtask

   task automatic read_check(input logic [ADDR_W-1:0] addr, input logic [RB_W-1:0] exp_v);
      bit got;
      bit ok;
      got = 1'b0;
      ok  = 1'b1;
      @(posedge radio_clk);
      i_rb_stb  <= 1'b1;
      i_rb_addr <= addr;
      @(posedge radio_clk);
      i_rb_stb  <= 1'b0;
      for (int n = 0; n < RB_WAIT && !got; n++)
      begin
         @(negedge radio_clk);
         got = o_rb_valid;
      end
      if (!got)
      begin
         $display("read of address %h got no answer within %0d cycles", addr, RB_WAIT);
         ok = 1'b0;
      end
      else
      begin
         ok = match_value("o_rb_data", exp_v, o_rb_data);
         if (addr == RB_DB_BASE + RB_MISC)   // misc out pin follows its register
            ok &= match_value("o_misc_out", exp_v[DATA_W-1:0], o_misc_out);
         if (addr == RB_DB_BASE + RB_ATR)    // ddr pins follow their register
            ok &= match_value("o_db_gpio_ddr", exp_v[RB_W-1:DATA_W], o_db_gpio_ddr);
         @(negedge radio_clk);
         if (o_rb_valid)
         begin
            $display("read of address %h was answered twice", addr);
            ok = 1'b0;
         end
      end
      finish_test($sformatf("read %h", addr), ok);
   endtask

   // atr outputs are one flop behind the run flags
   task automatic run_check(input logic [NUM_RX_CHANNELS-1:0] rx, input logic tx,
                            input logic [DATA_W-1:0] exp_gpio, input logic [2:0] exp_led);
      bit ok;
      @(posedge radio_clk);
      i_rx_running <= rx;
      i_tx_running <= tx;
      @(posedge radio_clk);
      @(negedge radio_clk);
      ok = match_value("o_db_gpio_out", exp_gpio, o_db_gpio_out);
      ok &= match_value("o_radio_led", exp_led, o_radio_led);
      finish_test($sformatf("run rx=%0d tx=%0d", rx, tx), ok);
   endtask

   task automatic send_sample(input int chan, input logic [15:0] si, input logic [15:0] sq,
                              input logic [15:0] ei, input logic [15:0] eq);
      flight_t f;
      @(posedge radio_clk);
      i_rx_stb <= (chan == NUM_RX_CHANNELS) ? '0 : NUM_RX_CHANNELS'(1 << chan);
      i_tx_stb <= (chan == NUM_RX_CHANNELS);
      if (chan == NUM_RX_CHANNELS)
         i_tx_sample <= {si, sq};
      else
         i_rx_samples[chan] <= {si, sq};
      f.chan  = chan[1:0];
      f.t_drv = $time;
      f.exp_i = ei;
      f.exp_q = eq;
      flight_q.push_back(f);
   endtask

   task automatic stop_samples();
      @(posedge radio_clk);
      i_rx_stb <= '0;
      i_tx_stb <= 1'b0;
   endtask

   task automatic wait_idle();
      for (int n = 0; n < DRAIN_WAIT && flight_q.size() != 0; n++)
         @(negedge radio_clk);
      if (flight_q.size() != 0)
      begin
         $display("%0d samples never came out of the correctors", flight_q.size());
         fail_cnt++;
         flight_q.delete();
      end
   endtask

   // --------------------
   // sample monitor
   // --------------------
   always @(negedge radio_clk)
   begin : sample_monitor
      int          chan;
      logic [31:0] got;
      flight_t     f;
      bit          ok;
      if ($countones({o_rx_stb, o_tx_stb}) > 1)
      begin
         $display("t=%0t more than one sample strobe in a cycle", $time);
         fail_cnt++;
      end
      else if (o_rx_stb != '0 || o_tx_stb)
      begin
         chan = NUM_RX_CHANNELS;   // tx unless an rx strobe is set
         for (int c = 0; c < NUM_RX_CHANNELS; c++)
            if (o_rx_stb[c])
               chan = c;
         got = (chan == NUM_RX_CHANNELS) ? o_tx_sample : o_rx_samples[chan];
         if (flight_q.size() == 0)
         begin
            $display("t=%0t sample strobe on channel %0d with nothing sent", $time, chan);
            fail_cnt++;
         end
         else
         begin
            f = flight_q.pop_front();
            ok = match_value("output channel", f.chan, chan);
            ok &= match_value(sample_name(chan, "i"), f.exp_i, got[31:16]);
            ok &= match_value(sample_name(chan, "q"), f.exp_q, got[15:0]);
            // two flops, seen at the following falling edge
            if ($time != f.t_drv + 2 * CLK_PERIOD + CLK_PERIOD / 2)
            begin
               $display("sample on channel %0d took %0d ns, not two cycles", chan,
                        $time - f.t_drv - CLK_PERIOD / 2);
               ok = 1'b0;
            end
            finish_test($sformatf("sample ch%0d", f.chan), ok);
         end
      end
   end

   // --------------------
   // main sequence
   // --------------------
   initial
   begin : main_seq
      int          fd;
      int          rc;
      int          c;
      int          n_lines;
      int          seed;
      int          chan;
      bit          done;
      logic [7:0]  op;
      logic [31:0] a;
      logic [63:0] ev;
      logic [31:0] eg;
      logic [31:0] el;
      logic [15:0] si, sq, ei, eq;
      seed         = $urandom(64);   // idle gaps only
      done         = 1'b0;
      n_lines      = 1;
      i_rst_n      = 1'b0;
      i_set_stb    = 1'b0;
      i_set_addr   = '0;
      i_set_data   = '0;
      i_rb_stb     = 1'b0;
      i_rb_addr    = '0;
      i_rx_running = '0;
      i_tx_running = 1'b0;
      i_rx_stb     = '0;
      i_rx_samples = '0;
      i_tx_stb     = 1'b0;
      i_tx_sample  = '0;
      i_db_gpio_in = '0;
      i_misc_in    = '0;
      fd = $fopen("radio_ctrl_tests.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open radio_ctrl_tests.txt");
         $display("Simulation failed");
         $finish;
      end
      else
      begin
         c = $fgetc(fd);   // count lines for the watchdog
         while (c != -1)
         begin
            if (c == "\n")
               n_lines++;
            c = $fgetc(fd);
         end
         $fclose(fd);
         wd_cycles = n_lines * 40;
         fd = $fopen("radio_ctrl_tests.txt", "r");
         repeat (3) @(posedge radio_clk);
         i_rst_n <= 1'b1;
         while (!done)
         begin
            rc = $fscanf(fd, " %c", op);
            if (rc != 1)
               done = 1'b1;   // end of file
            else if (op == "#")
               skip_line(fd);
            else if (op == "X")   // consecutive sample lines go back to back
            begin
               rc = $fscanf(fd, "%d %h %h %h %h", chan, si, sq, ei, eq);
               if (rc == 5 && chan >= 0 && chan <= NUM_RX_CHANNELS)
                  send_sample(chan, si, sq, ei, eq);
               else
                  bad_line(fd, op);
            end
            else
            begin
               stop_samples();
               wait_idle();   // config must not change under live samples
               repeat ($urandom % 3) @(posedge radio_clk);
               rc = $fscanf(fd, "%h %h", a, ev);
               if (op == "A")
                  rc = rc + $fscanf(fd, "%h %h", eg, el);
               if (rc != ((op == "A") ? 4 : 2))
                  bad_line(fd, op);
               else
                  case (op)
                     "W"     : write_reg(a[ADDR_W-1:0], ev[DATA_W-1:0]);
                     "R"     : read_check(a[ADDR_W-1:0], ev);
                     "A"     : run_check(a[NUM_RX_CHANNELS-1:0], ev[0], eg, el[2:0]);
                     "I"     : set_pins(a, ev[DATA_W-1:0]);
                     default : bad_line(fd, op);
                  endcase
            end
         end
         $fclose(fd);
         stop_samples();
         wait_idle();
         $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
         if (fail_cnt == 0)
            $display("Simulation completed successfully");
         else
            $display("Simulation failed");
         $finish;
      end
   end

endmodule
